// File: Bender.yml
package:
  name: cpu_frontend

sources:
  - logic/core_pkg.sv
  - logic/decode.sv
  - logic/instr_sequencer.sv
  - logic/program_counter.sv
  - logic/cpu_frontend.sv
  - target: test
    files:
      - test/tb_cpu_frontend.sv

// File: logic/core_pkg.sv
package core_pkg;

    // Program counter field widths
    localparam int PC_STEP_BITS = 8;
    localparam int PC_PAGE_BITS = 4;
    localparam int PC_BANK_BITS = 1;

    typedef logic [11:0] opcode_t;      // One program ROM word
    typedef logic [6:0]  ucode_addr_t;  // Microcode entry point
    typedef logic [7:0]  immed_t;       // Low byte of the opcode

    typedef logic [PC_BANK_BITS-1:0] pc_bank_t;
    typedef logic [PC_PAGE_BITS-1:0] pc_page_t;
    typedef logic [PC_STEP_BITS-1:0] pc_step_t;

    // Bank in the top bit, then page, step at the bottom
    typedef logic [PC_BANK_BITS+PC_PAGE_BITS+PC_STEP_BITS-1:0] pc_t;

    // Clock count inside one instruction
    typedef logic [3:0] cycle_count_t;

    // Encoded value is the length in clocks
    typedef enum cycle_count_t {
        CYCLE5  = 4'd5,
        CYCLE7  = 4'd7,
        CYCLE12 = 4'd12
    } instr_length;

    typedef enum logic {
        SEQ_FETCH,  // ROM word goes into the IR
        SEQ_EXEC    // Microcode owns the remaining clocks
    } seq_state_t;

    // Execution starts at bank 0, page 1, step 0
    localparam pc_t RESET_PC = {pc_bank_t'(0), pc_page_t'(1), pc_step_t'(0)};

endpackage

// File: logic/cpu_frontend.sv
`timescale 1ns/1ns

module cpu_frontend (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_pkg::opcode_t     rom_data,
    output core_pkg::pc_t         rom_addr,
    input  logic                  jump_en,
    input  core_pkg::pc_t         jump_pc,
    output logic                  dispatch,
    output logic                  instr_done,
    output core_pkg::ucode_addr_t ucode_addr,
    output core_pkg::immed_t      immed,
    output logic                  skip_pc_increment
);
    import core_pkg::*;

    opcode_t     opcode;        // IR contents
    instr_length cycle_length;  // Decoded length back to the sequencer

    instr_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .rom_data     (rom_data),
        .cycle_length (cycle_length),
        .opcode       (opcode),
        .dispatch     (dispatch),
        .instr_done   (instr_done)
    );

    decode u_decode (
        .opcode               (opcode),
        .skip_pc_increment    (skip_pc_increment),
        .microcode_start_addr (ucode_addr),
        .cycle_length         (cycle_length),
        .immed                (immed)
    );

    program_counter u_pc (
        .clk               (clk),
        .rst_n             (rst_n),
        .instr_done        (instr_done),
        .skip_pc_increment (skip_pc_increment),
        .jump_en           (jump_en),
        .jump_pc           (jump_pc),
        .pc                (rom_addr)  // PC addresses the ROM directly
    );

endmodule

// File: logic/decode.sv
`timescale 1ns/1ns

module decode (
    input  core_pkg::opcode_t     opcode,
    output logic                  skip_pc_increment,
    output core_pkg::ucode_addr_t microcode_start_addr,
    output core_pkg::instr_length cycle_length,
    output core_pkg::immed_t      immed
);
    import core_pkg::*;

    cycle_count_t clocks;  // Length before the cast back to the enum

    assign immed        = opcode[7:0];
    assign cycle_length = instr_length'(clocks);

    always_comb begin
        skip_pc_increment = 1'b0;
        {microcode_start_addr, clocks} = {7'd0, CYCLE5};  // Unlisted opcodes end up here
        casez (opcode[11:8])
            4'h0: {microcode_start_addr, clocks} = {7'd0, CYCLE5};  // JP s
            4'h1: begin  // RETD e
                {microcode_start_addr, clocks} = {7'd1, CYCLE12};
                skip_pc_increment = 1'b1;
            end
            4'h2: {microcode_start_addr, clocks} = {7'd2, CYCLE5};  // JP C, s
            4'h3: {microcode_start_addr, clocks} = {7'd3, CYCLE5};  // JP NC, s
            4'h4: begin  // CALL s
                {microcode_start_addr, clocks} = {7'd4, CYCLE7};
                skip_pc_increment = 1'b1;
            end
            4'h5: begin  // CALZ s
                {microcode_start_addr, clocks} = {7'd5, CYCLE7};
                skip_pc_increment = 1'b1;
            end
            4'h6: {microcode_start_addr, clocks} = {7'd6, CYCLE5};  // JP Z, s
            4'h7: {microcode_start_addr, clocks} = {7'd7, CYCLE5};  // JP NZ, s
            4'h8: {microcode_start_addr, clocks} = {7'd8, CYCLE5};  // LD Y, e
            4'h9: {microcode_start_addr, clocks} = {7'd9, CYCLE5};  // LBPX MX, e
            4'hA: begin
                casez (opcode[7:4])  // Arithmetic on index halves and r, q pairs
                    4'h0: {microcode_start_addr, clocks} = {7'd10, CYCLE7};  // ADC XH, i
                    4'h1: {microcode_start_addr, clocks} = {7'd11, CYCLE7};  // ADC XL, i
                    4'h2: {microcode_start_addr, clocks} = {7'd12, CYCLE7};  // ADC YH, i
                    4'h3: {microcode_start_addr, clocks} = {7'd13, CYCLE7};  // ADC YL, i
                    4'h4: {microcode_start_addr, clocks} = {7'd14, CYCLE7};  // CP XH, i
                    4'h5: {microcode_start_addr, clocks} = {7'd15, CYCLE7};  // CP XL, i
                    4'h6: {microcode_start_addr, clocks} = {7'd16, CYCLE7};  // CP YH, i
                    4'h7: {microcode_start_addr, clocks} = {7'd17, CYCLE7};  // CP YL, i
                    4'h8: {microcode_start_addr, clocks} = {7'd18, CYCLE7};  // ADD r, q
                    4'h9: {microcode_start_addr, clocks} = {7'd19, CYCLE7};  // ADC r, q
                    4'hA: {microcode_start_addr, clocks} = {7'd20, CYCLE7};  // SUB r, q
                    4'hB: {microcode_start_addr, clocks} = {7'd21, CYCLE7};  // SBC r, q
                    4'hC: {microcode_start_addr, clocks} = {7'd22, CYCLE7};  // AND r, q
                    4'hD: {microcode_start_addr, clocks} = {7'd23, CYCLE7};  // OR r, q
                    4'hE: {microcode_start_addr, clocks} = {7'd24, CYCLE7};  // XOR r, q
                    4'hF: {microcode_start_addr, clocks} = {7'd25, CYCLE7};  // RLC r
                endcase
            end
            4'hB: {microcode_start_addr, clocks} = {7'd26, CYCLE5};  // LD X, e
            4'hC: begin
                casez (opcode[7:6])
                    2'b00: {microcode_start_addr, clocks} = {7'd27, CYCLE7};  // ADD r, i
                    2'b01: {microcode_start_addr, clocks} = {7'd28, CYCLE7};  // ADC r, i
                    2'b10: {microcode_start_addr, clocks} = {7'd29, CYCLE7};  // AND r, i
                    2'b11: {microcode_start_addr, clocks} = {7'd30, CYCLE7};  // OR r, i
                endcase
            end
            4'hD: begin
                casez (opcode[7:6])
                    2'b00: {microcode_start_addr, clocks} = {7'd31, CYCLE7};  // XOR r, i
                    2'b01: {microcode_start_addr, clocks} = {7'd32, CYCLE7};  // SBC r, i
                    2'b10: {microcode_start_addr, clocks} = {7'd33, CYCLE7};  // FAN r, i
                    2'b11: {microcode_start_addr, clocks} = {7'd34, CYCLE7};  // CP r, i
                endcase
            end
            4'hE: begin
                // Holes at 1001_11, 1010_11, 1011_11 and 1101 are invalid
                casez (opcode[7:0])
                    8'b00??_????: {microcode_start_addr, clocks} = {7'd35, CYCLE5};  // LD r, i
                    8'b010?_????: {microcode_start_addr, clocks} = {7'd36, CYCLE5};  // PSET p
                    8'b0110_????: {microcode_start_addr, clocks} = {7'd37, CYCLE5};  // LDPX MX, i
                    8'b0111_????: {microcode_start_addr, clocks} = {7'd38, CYCLE5};  // LDPY MY, i
                    8'b1000_00??: {microcode_start_addr, clocks} = {7'd39, CYCLE5};  // LD XP, r
                    8'b1000_01??: {microcode_start_addr, clocks} = {7'd40, CYCLE5};  // LD XH, r
                    8'b1000_10??: {microcode_start_addr, clocks} = {7'd41, CYCLE5};  // LD XL, r
                    8'b1000_11??: {microcode_start_addr, clocks} = {7'd42, CYCLE5};  // RRC r
                    8'b1001_00??: {microcode_start_addr, clocks} = {7'd43, CYCLE5};  // LD YP, r
                    8'b1001_01??: {microcode_start_addr, clocks} = {7'd44, CYCLE5};  // LD YH, r
                    8'b1001_10??: {microcode_start_addr, clocks} = {7'd45, CYCLE5};  // LD YL, r
                    8'b1010_00??: {microcode_start_addr, clocks} = {7'd46, CYCLE5};  // LD r, XP
                    8'b1010_01??: {microcode_start_addr, clocks} = {7'd47, CYCLE5};  // LD r, XH
                    8'b1010_10??: {microcode_start_addr, clocks} = {7'd48, CYCLE5};  // LD r, XL
                    8'b1011_00??: {microcode_start_addr, clocks} = {7'd49, CYCLE5};  // LD r, YP
                    8'b1011_01??: {microcode_start_addr, clocks} = {7'd50, CYCLE5};  // LD r, YH
                    8'b1011_10??: {microcode_start_addr, clocks} = {7'd51, CYCLE5};  // LD r, YL
                    8'b1100_????: {microcode_start_addr, clocks} = {7'd52, CYCLE5};  // LD r, q
                    8'b1110_????: {microcode_start_addr, clocks} = {7'd53, CYCLE5};  // LDPX r, q
                    8'b1111_????: {microcode_start_addr, clocks} = {7'd54, CYCLE5};  // LDPY r, q
                    default: ;
                endcase
            end
            4'hF: begin
                casez (opcode[7:4])
                    4'h0: {microcode_start_addr, clocks} = {7'd55, CYCLE7};  // CP r, q
                    4'h1: {microcode_start_addr, clocks} = {7'd56, CYCLE7};  // FAN r, q
                    4'h2: begin
                        casez (opcode[3:2])
                            2'b10: {microcode_start_addr, clocks} = {7'd57, CYCLE7};  // ACPX MX, r
                            2'b11: {microcode_start_addr, clocks} = {7'd58, CYCLE7};  // ACPY MY, r
                            default: ;
                        endcase
                    end
                    4'h3: begin
                        casez (opcode[3:2])
                            2'b10: {microcode_start_addr, clocks} = {7'd59, CYCLE7};  // SCPX MX, r
                            2'b11: {microcode_start_addr, clocks} = {7'd60, CYCLE7};  // SCPY MY, r
                            default: ;
                        endcase
                    end
                    4'h4: {microcode_start_addr, clocks} = {7'd61, CYCLE7};  // SET F, i
                    4'h5: {microcode_start_addr, clocks} = {7'd62, CYCLE7};  // RST F, i
                    4'h6: {microcode_start_addr, clocks} = {7'd63, CYCLE7};  // INC Mn
                    4'h7: {microcode_start_addr, clocks} = {7'd64, CYCLE7};  // DEC Mn
                    4'h8: {microcode_start_addr, clocks} = {7'd65, CYCLE5};  // LD Mn, A
                    4'h9: {microcode_start_addr, clocks} = {7'd66, CYCLE5};  // LD Mn, B
                    4'hA: {microcode_start_addr, clocks} = {7'd67, CYCLE5};  // LD A, Mn
                    4'hB: {microcode_start_addr, clocks} = {7'd68, CYCLE5};  // LD B, Mn
                    4'hC: begin
                        casez (opcode[3:0])
                            4'b00??: {microcode_start_addr, clocks} = {7'd69, CYCLE5};  // PUSH r
                            4'b0100: {microcode_start_addr, clocks} = {7'd70, CYCLE5};  // PUSH XP
                            4'b0101: {microcode_start_addr, clocks} = {7'd71, CYCLE5};  // PUSH XH
                            4'b0110: {microcode_start_addr, clocks} = {7'd72, CYCLE5};  // PUSH XL
                            4'b0111: {microcode_start_addr, clocks} = {7'd73, CYCLE5};  // PUSH YP
                            4'b1000: {microcode_start_addr, clocks} = {7'd74, CYCLE5};  // PUSH YH
                            4'b1001: {microcode_start_addr, clocks} = {7'd75, CYCLE5};  // PUSH YL
                            4'b1010: {microcode_start_addr, clocks} = {7'd76, CYCLE5};  // PUSH F
                            4'b1011: {microcode_start_addr, clocks} = {7'd77, CYCLE5};  // DEC SP
                            default: ;
                        endcase
                    end
                    4'hD: begin
                        casez (opcode[3:0])
                            4'b00??: {microcode_start_addr, clocks} = {7'd78, CYCLE5};  // POP r
                            4'b0100: {microcode_start_addr, clocks} = {7'd79, CYCLE5};  // POP XP
                            4'b0101: {microcode_start_addr, clocks} = {7'd80, CYCLE5};  // POP XH
                            4'b0110: {microcode_start_addr, clocks} = {7'd81, CYCLE5};  // POP XL
                            4'b0111: {microcode_start_addr, clocks} = {7'd82, CYCLE5};  // POP YP
                            4'b1000: {microcode_start_addr, clocks} = {7'd83, CYCLE5};  // POP YH
                            4'b1001: {microcode_start_addr, clocks} = {7'd84, CYCLE5};  // POP YL
                            4'b1010: {microcode_start_addr, clocks} = {7'd85, CYCLE5};  // POP F
                            4'b1011: {microcode_start_addr, clocks} = {7'd86, CYCLE5};  // INC SP
                            4'b1110: {microcode_start_addr, clocks} = {7'd87, CYCLE12};  // RETS
                            4'b1111: begin  // RET
                                {microcode_start_addr, clocks} = {7'd88, CYCLE7};
                                skip_pc_increment = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    4'hE: begin
                        casez (opcode[3:0])
                            4'b00??: {microcode_start_addr, clocks} = {7'd89, CYCLE5};  // LD SPH, r
                            4'b01??: {microcode_start_addr, clocks} = {7'd90, CYCLE5};  // LD r, SPH
                            4'b1000: {microcode_start_addr, clocks} = {7'd91, CYCLE5};  // JPBA
                            default: ;
                        endcase
                    end
                    4'hF: begin
                        // Address 91 is shared with JPBA in the microcode map
                        casez (opcode[3:0])
                            4'b00??: {microcode_start_addr, clocks} = {7'd91, CYCLE5};  // LD SPL, r
                            4'b01??: {microcode_start_addr, clocks} = {7'd92, CYCLE5};  // LD r, SPL
                            4'b1000: {microcode_start_addr, clocks} = {7'd93, CYCLE5};  // HALT
                            4'b1001: {microcode_start_addr, clocks} = {7'd94, CYCLE5};  // SLP
                            4'b1011: {microcode_start_addr, clocks} = {7'd95, CYCLE5};  // NOP5
                            4'b1111: {microcode_start_addr, clocks} = {7'd96, CYCLE7};  // NOP7
                            default: ;
                        endcase
                    end
                endcase
            end
        endcase
    end

endmodule

// File: logic/instr_sequencer.sv
`timescale 1ns/1ns

module instr_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_pkg::opcode_t     rom_data,
    input  core_pkg::instr_length cycle_length,
    output core_pkg::opcode_t     opcode,
    output logic                  dispatch,
    output logic                  instr_done
);
    import core_pkg::*;

    seq_state_t   state;
    cycle_count_t count;       // Clocks since the fetch cycle
    cycle_count_t next_count;
    cycle_count_t last_count;  // Count of the final execute clock

    assign next_count = count + 1'b1;
    assign last_count = cycle_length - 1'b1;

    // Instruction register
    always_ff @(posedge clk) begin
        if (state == SEQ_FETCH) begin
            opcode <= rom_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= SEQ_FETCH;
            count      <= '0;
            dispatch   <= 1'b0;
            instr_done <= 1'b0;
        end else begin
            dispatch   <= 1'b0;  // Both strobes last one clock
            instr_done <= 1'b0;
            case (state)
                SEQ_FETCH: begin
                    state    <= SEQ_EXEC;
                    count    <= cycle_count_t'(1);
                    dispatch <= 1'b1;  // Decode of the new IR is valid next cycle
                end
                SEQ_EXEC: begin
                    if (instr_done) begin
                        state <= SEQ_FETCH;
                        count <= '0;
                    end else begin
                        count      <= next_count;
                        instr_done <= (next_count == last_count);
                    end
                end
            endcase
        end
    end

    a_no_strobe_in_fetch: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == SEQ_FETCH |-> !dispatch && !instr_done
    ) else $error("Strobe seen while fetching");

    // A new dispatch must come between two completions
    a_done_after_dispatch: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_done |=> !instr_done throughout dispatch[->1]
    ) else $error("instr_done without a preceding dispatch");

endmodule

// File: logic/program_counter.sv
`timescale 1ns/1ns

module program_counter (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          instr_done,
    input  logic          skip_pc_increment,
    input  logic          jump_en,
    input  core_pkg::pc_t jump_pc,
    output core_pkg::pc_t pc
);
    import core_pkg::*;

    pc_bank_t bank;
    pc_page_t page;
    pc_step_t step;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {bank, page, step} <= RESET_PC;
        end else if (instr_done) begin
            if (jump_en) begin
                {bank, page, step} <= jump_pc;  // Jump wins over skip
            end else if (!skip_pc_increment) begin
                step <= step + 1'b1;  // Wraps inside the page
            end
        end
    end

    assign pc = {bank, page, step};

    // Sequential flow never leaves the current page
    a_increment_in_page: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_done && !jump_en && !skip_pc_increment
            |=> $stable(bank) && $stable(page) && step == $past(step) + 1'b1
    ) else $error("PC increment crossed a page or bank");

endmodule

// File: sim.f
logic/core_pkg.sv
logic/decode.sv
logic/instr_sequencer.sv
logic/program_counter.sv
logic/cpu_frontend.sv
test/tb_cpu_frontend.sv

// File: test/tb_cpu_frontend.sv
`timescale 1ns/1ns

module tb_cpu_frontend;
    import core_pkg::*;

    localparam int NUM_OPS    = 24;
    localparam int NUM_SKIPS  = 4;
    localparam int NUM_RANDOM = 20;
    // Skip opcodes run twice and the wrap test adds four instructions
    localparam int MAX_CYCLES = 12 * (NUM_OPS + NUM_SKIPS + 2 * NUM_RANDOM + 4) + 100;

    logic        clk;
    logic        rst_n;
    opcode_t     rom_data;
    pc_t         rom_addr;
    logic        jump_en;
    pc_t         jump_pc;
    logic        dispatch;
    logic        instr_done;
    ucode_addr_t ucode_addr;
    immed_t      immed;
    logic        skip_pc_increment;

    opcode_t rom [0:8191];  // One word per PC value
    int      cycle = 0;
    int      last_dispatch;
    int      last_len;      // Zero right after reset
    integer  seed;

    // Reference opcode map with one entry per category
    opcode_t op_tab [0:NUM_OPS-1] = '{
        12'h000, 12'h1A5, 12'h3FF, 12'h412, 12'h507, 12'h8C3, 12'hA9B, 12'hB81,
        12'hCC5, 12'hDB3, 12'hE5A, 12'hE9A, 12'hE9C, 12'hF29, 12'hF3F, 12'hF23,
        12'hFC6, 12'hFDE, 12'hFDF, 12'hFE8, 12'hFF2, 12'hFF8, 12'hFFF, 12'hED0};
    int      addr_tab [0:NUM_OPS-1] = '{
        0, 1, 3, 4, 5, 8, 19, 26, 30, 33, 36, 45, 0, 57, 60, 0,
        72, 87, 88, 91, 91, 93, 96, 0};
    int      len_tab [0:NUM_OPS-1] = '{
        5, 12, 5, 7, 7, 5, 7, 5, 7, 7, 5, 5, 5, 7, 7, 5,
        5, 12, 7, 5, 5, 5, 7, 5};
    logic    skip_tab [0:NUM_OPS-1] = '{
        0, 1, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
        0, 0, 1, 0, 0, 0, 0, 0};

    cpu_frontend uut (.*);

    assign rom_data = rom[rom_addr];  // Combinational ROM read

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: the run took more than %0d clock cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Run aborted");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch on %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Value check failed");
        end
    endtask

    function automatic pc_t jump_target(input pc_t pc);
        return pc ^ 13'h1A5C;  // Other bank, page and step
    endfunction

    task automatic fill_rom();
        int a;
        for (a = 0; a < 8192; a++) begin
            rom[a] = {4'h0, a[7:0] ^ {3'b000, a[12:8]}};  // JP s words
        end
    endtask

    task automatic apply_reset();
        int i;
        rst_n   = 1'b0;
        jump_en = 1'b0;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            expect_equal("dispatch", dispatch, 1'b0);
            expect_equal("instr_done", instr_done, 1'b0);
        end
        expect_equal("rom_addr", rom_addr, RESET_PC);
        rst_n    = 1'b1;  // Next rising edge is the first fetch
        last_len = 0;
    endtask

    // Runs one instruction from fetch to PC update and returns the expected next PC
    task automatic execute_instr(input pc_t pc_exp, input int idx, input logic take_jump,
                                 input pc_t target, output pc_t pc_next);
        int waited;
        int start;
        waited = 0;
        while (!dispatch) begin
            @(negedge clk);
            waited++;
            if (waited > 12) abort_run("No dispatch arrived after the fetch");
        end
        expect_equal("rom_addr", rom_addr, pc_exp);
        expect_equal("ucode_addr", ucode_addr, addr_tab[idx]);
        expect_equal("immed", immed, op_tab[idx][7:0]);
        expect_equal("skip_pc_increment", skip_pc_increment, skip_tab[idx]);
        if (last_len != 0) begin
            expect_equal("dispatch spacing", cycle - last_dispatch, last_len);
        end
        last_dispatch = cycle;
        last_len      = len_tab[idx];
        jump_en       = take_jump;  // Level sampled only with instr_done
        jump_pc       = target;
        start         = cycle;
        while (!instr_done) begin
            @(negedge clk);
            if (cycle - start > 12) abort_run("instr_done never followed the dispatch");
        end
        expect_equal("instr_done offset", cycle - start, len_tab[idx] - 2);
        expect_equal("rom_addr", rom_addr, pc_exp);  // PC moves one clock later
        @(negedge clk);
        jump_en = 1'b0;
        pc_next = pc_exp;
        if (take_jump) begin
            pc_next = target;
        end else if (!skip_tab[idx]) begin
            pc_next[PC_STEP_BITS-1:0] = pc_exp[PC_STEP_BITS-1:0] + 1'b1;
        end
        expect_equal("rom_addr", rom_addr, pc_next);
    endtask

    // A skip opcode holds the PC, runs again and then leaves by a jump
    task automatic run_entry(input int idx, inout pc_t pc);
        pc_t next;
        rom[pc] = op_tab[idx];
        execute_instr(pc, idx, 1'b0, '0, next);
        if (skip_tab[idx]) begin
            execute_instr(pc, idx, 1'b1, jump_target(pc), next);
        end
        pc = next;
    endtask

    task automatic decode_map_test();
        pc_t pc;
        int  i;
        fill_rom();
        apply_reset();
        pc = RESET_PC;
        for (i = 0; i < NUM_OPS; i++) begin
            run_entry(i, pc);
        end
    endtask

    task automatic random_timing_test();
        pc_t pc;
        int  i;
        int  idx;
        fill_rom();
        apply_reset();
        pc = RESET_PC;
        for (i = 0; i < NUM_RANDOM; i++) begin
            idx = $unsigned($random(seed)) % NUM_OPS;
            run_entry(idx, pc);
        end
    endtask

    task automatic page_wrap_test();
        pc_t start;
        pc_t pc;
        start = {1'b1, 4'h6, 8'hFE};
        fill_rom();
        apply_reset();
        rom[RESET_PC] = op_tab[0];
        execute_instr(RESET_PC, 0, 1'b1, start, pc);
        run_entry(22, pc);  // NOP7 at step FE
        run_entry(21, pc);  // HALT at step FF
        expect_equal("rom_addr step after wrap", rom_addr[PC_STEP_BITS-1:0], 8'h00);
        expect_equal("rom_addr bank and page after wrap", rom_addr[12:8], {1'b1, 4'h6});
        run_entry(0, pc);
    endtask

    initial begin
        rst_n   = 1'b0;
        jump_en = 1'b0;
        jump_pc = '0;
        seed    = 32'ha92ce709;
        decode_map_test();
        random_timing_test();
        page_wrap_test();
        $display("=== PASS ===");
        $finish;
    end

endmodule
